//--- hw/fpslice_pkg.sv
`default_nettype none

package fpslice_pkg;

  // ------------------------------
  // Widths and lane count
  // ------------------------------
  localparam int unsigned SLICE_WIDTH  = 32;
  localparam int unsigned NUM_LANES    = 4;
  localparam int unsigned FMT_WIDTH_32 = 32;
  localparam int unsigned FMT_WIDTH_16 = 16;
  localparam int unsigned FMT_WIDTH_8  = 8;

  typedef logic [SLICE_WIDTH-1:0] fp_word_t;   // Operand, result and lane value
  typedef logic [NUM_LANES-1:0]   lane_mask_t; // One bit per lane

  localparam fp_word_t ALL_ONES = '1;

  // FP8 is 1 sign, 5 exponent, 2 mantissa bits
  typedef enum logic [1:0] {
    FMT_FP32 = 2'd0,
    FMT_FP16 = 2'd1,
    FMT_FP8  = 2'd2
  } fp_fmt_e;

  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } noncomp_op_e;

  typedef struct packed {
    logic nv; // Invalid operation
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef struct packed {
    fp_fmt_e fmt;
    logic    vectorial;
  } slice_aux_t;

  typedef struct packed {
    fp_word_t    opa; // Right-aligned lane operand
    fp_word_t    opb;
    noncomp_op_e op;
    slice_aux_t  aux;
    logic        mask;
  } lane_req_t;

  typedef struct packed {
    fp_word_t   result; // Right-aligned, ones above the format width
    status_t    status;
    slice_aux_t aux;
    logic       mask;
    logic       valid;
  } lane_rsp_t;

  // ------------------------------
  // Format helpers
  // ------------------------------
  function automatic int unsigned fmt_width(fp_fmt_e fmt);
    case (fmt)
      FMT_FP16: return FMT_WIDTH_16;
      FMT_FP8:  return FMT_WIDTH_8;
      default:  return FMT_WIDTH_32;
    endcase
  endfunction

  // Lanes a vectorial op of this format occupies
  function automatic int unsigned fmt_lanes(fp_fmt_e fmt);
    return SLICE_WIDTH / fmt_width(fmt);
  endfunction

  function automatic fp_word_t fmt_inf(fp_fmt_e fmt);
    case (fmt)
      FMT_FP16: return 32'h0000_7c00;
      FMT_FP8:  return 32'h0000_007c;
      default:  return 32'h7f80_0000;
    endcase
  endfunction

  // Mantissa MSB, set for quiet NaNs
  function automatic fp_word_t fmt_quiet(fp_fmt_e fmt);
    case (fmt)
      FMT_FP16: return 32'h0000_0200;
      FMT_FP8:  return 32'h0000_0002;
      default:  return 32'h0040_0000;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hw/lane_operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module lane_operand_select (
  input  fpslice_pkg::fp_word_t                            opa_i,
  input  fpslice_pkg::fp_word_t                            opb_i,
  input  fpslice_pkg::noncomp_op_e                         op_i,
  input  fpslice_pkg::fp_fmt_e                             fmt_i,
  input  logic                                             vectorial_op_i,
  input  fpslice_pkg::lane_mask_t                          simd_mask_i,
  input  logic                                             in_valid_i,
  output fpslice_pkg::lane_req_t [fpslice_pkg::NUM_LANES-1:0] lane_req_o,
  output fpslice_pkg::lane_mask_t                          lane_valid_o
);

  import fpslice_pkg::*;

  slice_aux_t  aux;
  int unsigned lane_w;   // Slot width of the current format
  int unsigned lane_cnt; // Lanes covered by the current format
  lane_mask_t  lane_used;

  assign aux.fmt       = fmt_i;
  assign aux.vectorial = vectorial_op_i;

  assign lane_w   = fmt_width(fmt_i);
  assign lane_cnt = fmt_lanes(fmt_i);

  // ------------------------------
  // Lane use
  // ------------------------------
  // Lane 0 always works, upper lanes only for vectors that reach them
  always_comb begin : lane_use
    for (int unsigned i = 0; i < NUM_LANES; i++) begin
      lane_used[i] = (i == 0) || (vectorial_op_i && (i < lane_cnt));
    end
  end

  assign lane_valid_o = lane_used & {NUM_LANES{in_valid_i}};

  // ------------------------------
  // Operand slicing
  // ------------------------------
  always_comb begin : slice_operands
    for (int unsigned i = 0; i < NUM_LANES; i++) begin
      lane_req_o[i].opa  = opa_i >> (i * lane_w); // Upper bits dropped in the lane
      lane_req_o[i].opb  = opb_i >> (i * lane_w);
      lane_req_o[i].op   = op_i;
      lane_req_o[i].aux  = aux;
      lane_req_o[i].mask = simd_mask_i[i];
    end
  end

endmodule

`default_nettype wire

//--- hw/noncomp_lane.sv
`timescale 1ns/1ps
`default_nettype none

module noncomp_lane #(
  parameter int unsigned LANE_IDX = 0
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  fpslice_pkg::lane_req_t req_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  logic                   out_ready_i,
  output fpslice_pkg::lane_rsp_t rsp_o
);

  import fpslice_pkg::*;

  if (LANE_IDX >= NUM_LANES) begin : gen_bad_lane
    $fatal(1, "noncomp_lane: LANE_IDX %0d out of range", LANE_IDX);
  end

  fp_word_t fmt_mask;  // Ones over the format width
  fp_word_t sign_bit;
  fp_word_t quiet_bit;
  fp_word_t inf_pat;
  fp_word_t a_val, b_val;
  fp_word_t a_mag, b_mag;
  logic     a_sign, b_sign;
  logic     a_nan, b_nan;
  logic     a_snan, b_snan;
  logic     a_lt_b;
  logic     inj_sign;
  logic     is_minmax;
  fp_word_t sel_result;
  fp_word_t op_result;
  status_t  op_status;

  logic       valid_q;
  fp_word_t   result_q;
  status_t    status_q;
  slice_aux_t aux_q;
  logic       mask_q;

  // ------------------------------
  // Operand classification
  // ------------------------------
  always_comb begin : classify
    fmt_mask  = ALL_ONES >> (SLICE_WIDTH - fmt_width(req_i.aux.fmt));
    sign_bit  = fp_word_t'(1) << (fmt_width(req_i.aux.fmt) - 1);
    quiet_bit = fmt_quiet(req_i.aux.fmt);
    inf_pat   = fmt_inf(req_i.aux.fmt);

    a_val  = req_i.opa & fmt_mask;
    b_val  = req_i.opb & fmt_mask;
    a_mag  = a_val & ~sign_bit;
    b_mag  = b_val & ~sign_bit;
    a_sign = |(a_val & sign_bit);
    b_sign = |(b_val & sign_bit);

    // Magnitude above infinity means NaN
    a_nan  = a_mag > inf_pat;
    b_nan  = b_mag > inf_pat;
    a_snan = a_nan && ((a_mag & quiet_bit) == '0);
    b_snan = b_nan && ((b_mag & quiet_bit) == '0);

    // Sign-magnitude order, -0 sorts below +0
    if (a_sign != b_sign) begin
      a_lt_b = a_sign;
    end else if (a_sign) begin
      a_lt_b = a_mag > b_mag;
    end else begin
      a_lt_b = a_mag < b_mag;
    end
  end

  // ------------------------------
  // Operation
  // ------------------------------
  assign is_minmax = (req_i.op == OP_MIN) || (req_i.op == OP_MAX);

  always_comb begin : compute
    op_status = '0;
    case (req_i.op)
      OP_SGNJN: inj_sign = ~b_sign;
      OP_SGNJX: inj_sign = a_sign ^ b_sign;
      default:  inj_sign = b_sign;
    endcase
    sel_result = a_mag | (inj_sign ? sign_bit : '0);

    if (is_minmax) begin
      op_status.nv = a_snan | b_snan;
      if (a_nan && b_nan) begin
        sel_result = inf_pat | quiet_bit; // Canonical quiet NaN
      end else if (a_nan) begin
        sel_result = b_val;
      end else if (b_nan) begin
        sel_result = a_val;
      end else if (a_lt_b ^ (req_i.op == OP_MAX)) begin
        sel_result = a_val;
      end else begin
        sel_result = b_val;
      end
    end

    op_result = sel_result | ~fmt_mask; // NaN-box above the format
  end

  // ------------------------------
  // Output stage
  // ------------------------------
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      result_q <= op_result;
      status_q <= op_status;
      aux_q    <= req_i.aux;
      mask_q   <= req_i.mask;
    end
  end

  assign rsp_o.result = result_q;
  assign rsp_o.status = status_q;
  assign rsp_o.aux    = aux_q;
  assign rsp_o.mask   = mask_q;
  assign rsp_o.valid  = valid_q;

  // Only lanes inside the format's lane count may be offered work
  a_fmt_supported: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i |-> (LANE_IDX < fmt_lanes(req_i.aux.fmt)))
    else $error("lane %0d got unsupported format %s", LANE_IDX, req_i.aux.fmt.name());

  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_q && !out_ready_i) |=> (valid_q && $stable(rsp_o)))
    else $error("lane %0d response changed under back-pressure", LANE_IDX);

endmodule

`default_nettype wire

//--- hw/result_pack.sv
`timescale 1ns/1ps
`default_nettype none

module result_pack (
  input  fpslice_pkg::lane_rsp_t [fpslice_pkg::NUM_LANES-1:0] lane_rsp_i,
  output fpslice_pkg::fp_word_t                               result_o,
  output fpslice_pkg::status_t                                status_o
);

  import fpslice_pkg::*;

  fp_fmt_e    res_fmt;
  logic       res_vec;
  lane_mask_t lane_in_use; // Valid lanes belonging to this result
  lane_mask_t lane_needed;
  fp_word_t   fp32_res, fp16_res, fp8_res;

  // Lane 0 carries the format of the whole result
  assign res_fmt = lane_rsp_i[0].aux.fmt;
  assign res_vec = lane_rsp_i[0].aux.vectorial;

  always_comb begin : lane_use
    for (int unsigned i = 0; i < NUM_LANES; i++) begin
      lane_in_use[i] = lane_rsp_i[i].valid && ((i == 0) || res_vec);
      lane_needed[i] = (i == 0) || (res_vec && (i < fmt_lanes(res_fmt)));
    end
  end

  // Put each lane's low bits in its slot, untouched slots stay all ones
  function automatic fp_word_t pack_slots(
    input lane_rsp_t [NUM_LANES-1:0] rsp,
    input lane_mask_t                use_lane,
    input int unsigned               w
  );
    fp_word_t word;
    fp_word_t slot_mask;
    word      = ALL_ONES;
    slot_mask = ALL_ONES >> (SLICE_WIDTH - w);
    for (int unsigned i = 0; i < NUM_LANES; i++) begin
      if (use_lane[i] && ((i + 1) * w <= SLICE_WIDTH)) begin
        word = (word & ~(slot_mask << (i * w))) | ((rsp[i].result & slot_mask) << (i * w));
      end
    end
    return word;
  endfunction

  // ------------------------------
  // Result assembly
  // ------------------------------
  assign fp32_res = pack_slots(lane_rsp_i, lane_in_use, FMT_WIDTH_32);
  assign fp16_res = pack_slots(lane_rsp_i, lane_in_use, FMT_WIDTH_16);
  assign fp8_res  = pack_slots(lane_rsp_i, lane_in_use, FMT_WIDTH_8);

  always_comb begin : fmt_select
    case (res_fmt)
      FMT_FP16: result_o = fp16_res;
      FMT_FP8:  result_o = fp8_res;
      default:  result_o = fp32_res;
    endcase
  end

  // Masked-off lanes never contribute flags
  always_comb begin : status_collapse
    status_o = '0;
    for (int unsigned i = 0; i < NUM_LANES; i++) begin
      if (lane_in_use[i] && lane_rsp_i[i].mask) begin
        status_o = status_o | lane_rsp_i[i].status;
      end
    end
  end

  // A vector result must have every covered lane filled
  always_comb begin : vec_complete_check
    if (lane_rsp_i[0].valid && res_vec) begin
      a_vec_complete: assert ((lane_needed & ~lane_in_use) == '0)
        else $error("vector result missing lanes, needed %h valid %h", lane_needed, lane_in_use);
    end
  end

endmodule

`default_nettype wire

//--- hw/simd_fp_slice.sv
`timescale 1ns/1ps
`default_nettype none

module simd_fp_slice (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Operands and control
  input  fpslice_pkg::fp_word_t    opa_i,
  input  fpslice_pkg::fp_word_t    opb_i,
  input  fpslice_pkg::noncomp_op_e op_i,
  input  fpslice_pkg::fp_fmt_e     fmt_i,
  input  logic                     vectorial_op_i,
  input  fpslice_pkg::lane_mask_t  simd_mask_i,
  // Input handshake
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  // Result side
  output fpslice_pkg::fp_word_t    result_o,
  output fpslice_pkg::status_t     status_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o
);

  import fpslice_pkg::*;

  lane_req_t [NUM_LANES-1:0] lane_req;
  lane_rsp_t [NUM_LANES-1:0] lane_rsp;
  lane_mask_t                lane_used_valid; // in_valid_i gated by lane use
  lane_mask_t                lane_in_valid;
  lane_mask_t                lane_in_ready;
  lane_mask_t                lane_out_valid;

  // ------------------------------
  // Input side
  // ------------------------------
  lane_operand_select u_select (
    .opa_i          ( opa_i           ),
    .opb_i          ( opb_i           ),
    .op_i           ( op_i            ),
    .fmt_i          ( fmt_i           ),
    .vectorial_op_i ( vectorial_op_i  ),
    .simd_mask_i    ( simd_mask_i     ),
    .in_valid_i     ( in_valid_i      ),
    .lane_req_o     ( lane_req        ),
    .lane_valid_o   ( lane_used_valid )
  );

  // Lanes only load when lane 0 accepts, keeps them in step
  assign lane_in_valid = lane_used_valid & {NUM_LANES{lane_in_ready[0]}};

  // ------------------------------
  // Lanes
  // ------------------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    noncomp_lane #(
      .LANE_IDX ( l )
    ) u_lane (
      .clk_i       ( clk_i            ),
      .rst_i       ( rst_i            ),
      .req_i       ( lane_req[l]      ),
      .in_valid_i  ( lane_in_valid[l] ),
      .in_ready_o  ( lane_in_ready[l] ),
      .out_ready_i ( out_ready_i      ), // Same ready to every lane
      .rsp_o       ( lane_rsp[l]      )
    );

    assign lane_out_valid[l] = lane_rsp[l].valid;
  end

  // ------------------------------
  // Output side
  // ------------------------------
  result_pack u_pack (
    .lane_rsp_i ( lane_rsp ),
    .result_o   ( result_o ),
    .status_o   ( status_o )
  );

  assign in_ready_o  = lane_in_ready[0];
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_out_valid;

  // No lane may be handed a request it cannot take
  a_lanes_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    (lane_in_valid & ~lane_in_ready) == '0)
    else $error("lane offered work while full, valid %h ready %h",
                lane_in_valid, lane_in_ready);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the SIMD slice testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_simd_fp_slice \
  -Mdir obj_dir -o sim_tb

sim_status=0
./obj_dir/sim_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if [ "$sim_status" -eq 0 ] && grep -qx "Verification passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- include/noncomp_ref.svh
`ifndef NONCOMP_REF_SVH
`define NONCOMP_REF_SVH

function automatic int unsigned ref_width(fpslice_pkg::fp_fmt_e fmt);
  case (fmt)
    fpslice_pkg::FMT_FP16: return 16;
    fpslice_pkg::FMT_FP8:  return 8;
    default:               return 32;
  endcase
endfunction

// Exponent field width, FP16 and FP8 share five bits
function automatic int unsigned ref_exp_bits(fpslice_pkg::fp_fmt_e fmt);
  return (fmt == fpslice_pkg::FMT_FP32) ? 8 : 5;
endfunction

function automatic logic ref_is_nan(logic [31:0] v, fpslice_pkg::fp_fmt_e fmt);
  int unsigned man_bits;
  logic [31:0] exp_f;
  logic [31:0] man_f;
  man_bits = ref_width(fmt) - 1 - ref_exp_bits(fmt);
  exp_f    = (v >> man_bits) & ((32'd1 << ref_exp_bits(fmt)) - 1);
  man_f    = v & ((32'd1 << man_bits) - 1);
  return (exp_f == ((32'd1 << ref_exp_bits(fmt)) - 1)) && (man_f != 0);
endfunction

function automatic logic ref_is_snan(logic [31:0] v, fpslice_pkg::fp_fmt_e fmt);
  int unsigned man_bits;
  man_bits = ref_width(fmt) - 1 - ref_exp_bits(fmt);
  return ref_is_nan(v, fmt) && !v[man_bits-1];
endfunction

// One lane result, upper bits NaN-boxed
function automatic logic [31:0] ref_lane_op(logic [31:0] a, logic [31:0] b,
                                            fpslice_pkg::noncomp_op_e op,
                                            fpslice_pkg::fp_fmt_e fmt, output logic nv);
  int unsigned w;
  logic [31:0] fm, sb, ma, mb, res;
  logic sa, sgn_b, a_lt_b;
  w  = ref_width(fmt);
  fm = 32'hffff_ffff >> (32 - w);
  sb = 32'd1 << (w - 1);
  a  = a & fm;
  b  = b & fm;
  ma = a & ~sb;
  mb = b & ~sb;
  sa    = a[w-1];
  sgn_b = b[w-1];
  nv    = 1'b0;
  a_lt_b = (sa != sgn_b) ? sa : (sa ? (ma > mb) : (ma < mb));
  case (op)
    fpslice_pkg::OP_SGNJN: res = ma | (sgn_b ? 32'd0 : sb);
    fpslice_pkg::OP_SGNJX: res = ma | ((sa ^ sgn_b) ? sb : 32'd0);
    fpslice_pkg::OP_MIN, fpslice_pkg::OP_MAX: begin
      nv = ref_is_snan(a, fmt) || ref_is_snan(b, fmt);
      if (ref_is_nan(a, fmt) && ref_is_nan(b, fmt)) begin
        res = (fm >> 1) & ~(fm >> (ref_exp_bits(fmt) + 2));
      end else if (ref_is_nan(a, fmt)) begin
        res = b;
      end else if (ref_is_nan(b, fmt)) begin
        res = a;
      end else begin
        res = (a_lt_b == (op == fpslice_pkg::OP_MIN)) ? a : b;
      end
    end
    default: res = ma | (sgn_b ? sb : 32'd0);
  endcase
  return res | ~fm;
endfunction

// Whole 32-bit result and masked status
function automatic logic [31:0] ref_slice(logic [31:0] opa, logic [31:0] opb,
                                          fpslice_pkg::noncomp_op_e op,
                                          fpslice_pkg::fp_fmt_e fmt, logic vec,
                                          logic [3:0] mask,
                                          output fpslice_pkg::status_t status);
  int unsigned w, lanes;
  logic [31:0] fm, slot, res;
  logic nv;
  w      = ref_width(fmt);
  lanes  = vec ? (32 / w) : 1;
  fm     = 32'hffff_ffff >> (32 - w);
  res    = 32'hffff_ffff;
  status = '0;
  for (int unsigned i = 0; i < lanes; i++) begin
    slot = ref_lane_op(opa >> (i * w), opb >> (i * w), op, fmt, nv);
    res  = (res & ~(fm << (i * w))) | ((slot & fm) << (i * w));
    if (mask[i] && nv) status.nv = 1'b1;
  end
  return res;
endfunction

`endif

//--- testbench/tb_simd_fp_slice.sv
`timescale 1ns/1ps
`default_nettype none

module tb_simd_fp_slice;

  import fpslice_pkg::*;

  `include "noncomp_ref.svh"

  typedef struct packed {
    fp_word_t result;
    status_t  status;
  } expect_t;

  localparam int unsigned N_SGNJ    = 60; // Per sign-injection op
  localparam int unsigned N_MINMAX  = 150;
  localparam int unsigned N_VEC     = 200;
  localparam int unsigned N_BP      = 300;
  localparam int unsigned TOTAL_OPS = 1 + 3 * N_SGNJ + 12 + N_MINMAX + N_VEC + N_BP;
  localparam int unsigned MAX_CYCLES = TOTAL_OPS * 40 + 200;

  logic        clk = 1'b0;
  logic        rst;
  fp_word_t    opa;
  fp_word_t    opb;
  noncomp_op_e op;
  fp_fmt_e     fmt;
  logic        vec;
  lane_mask_t  mask;
  logic        in_valid;
  logic        in_ready;
  fp_word_t    result;
  status_t     status;
  logic        out_valid;
  logic        out_ready;
  logic        busy;

  integer  seed = 83;
  logic    bp_on;       // Random out_ready when set
  expect_t exp_q[$];
  int      chk_errors = 0;
  int      seq_errors = 0;
  int      tests_passed = 0;
  int      tests_failed = 0;
  int      err_mark = 0;
  logic    hold_prev;
  fp_word_t held_result;
  status_t held_status;
  expect_t pop_exp;
  expect_t push_exp;
  status_t push_st;

  simd_fp_slice dut (
    .clk_i          ( clk       ),
    .rst_i          ( rst       ),
    .opa_i          ( opa       ),
    .opb_i          ( opb       ),
    .op_i           ( op        ),
    .fmt_i          ( fmt       ),
    .vectorial_op_i ( vec       ),
    .simd_mask_i    ( mask      ),
    .in_valid_i     ( in_valid  ),
    .in_ready_o     ( in_ready  ),
    .result_o       ( result    ),
    .status_o       ( status    ),
    .out_valid_o    ( out_valid ),
    .out_ready_i    ( out_ready ),
    .busy_o         ( busy      )
  );

  always #20 clk = ~clk;

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  function automatic int unsigned rand_below(int unsigned n);
    int unsigned u;
    u = $random(seed);
    return u % n;
  endfunction

  // Zeros, infinities and both NaN kinds show up often
  function automatic fp_word_t biased_value(fp_fmt_e f);
    int unsigned w, eb, mb;
    fp_word_t    r, sgn, exp_ones, man_lo;
    w        = ref_width(f);
    eb       = ref_exp_bits(f);
    mb       = w - 1 - eb;
    r        = $random(seed);
    sgn      = r[31] ? (32'd1 << (w - 1)) : 32'd0;
    exp_ones = ((32'd1 << eb) - 1) << mb;
    man_lo   = (r >> 1) & ((32'd1 << (mb - 1)) - 1); // Below the quiet bit
    case (rand_below(8))
      0:       return sgn;
      1:       return sgn | exp_ones;
      2:       return sgn | exp_ones | (32'd1 << (mb - 1)) | man_lo;
      3:       return sgn | exp_ones | man_lo | 32'd1; // Signalling NaN
      default: return r & (32'hffff_ffff >> (32 - w));
    endcase
  endfunction

  // Unused slots keep random garbage
  function automatic fp_word_t make_operand(fp_fmt_e f, logic v);
    int unsigned w, lanes;
    fp_word_t    word, fm;
    w     = ref_width(f);
    lanes = v ? 32 / w : 1;
    fm    = 32'hffff_ffff >> (32 - w);
    word  = $random(seed);
    for (int unsigned i = 0; i < lanes; i++) begin
      word = (word & ~(fm << (i * w))) | (biased_value(f) << (i * w));
    end
    return word;
  endfunction

  task automatic step();
    @(posedge clk);
    out_ready <= bp_on ? (rand_below(4) != 0) : 1'b1;
  endtask

  task automatic send_op(input fp_word_t a, input fp_word_t b, input noncomp_op_e o,
                         input fp_fmt_e f, input logic v, input lane_mask_t m);
    opa      <= a;
    opb      <= b;
    op       <= o;
    fmt      <= f;
    vec      <= v;
    mask     <= m;
    in_valid <= 1'b1;
    do begin
      step();
    end while (!in_ready);
  endtask

  task automatic send_random(input noncomp_op_e o, input fp_fmt_e f, input logic v,
                             input lane_mask_t m);
    send_op(make_operand(f, v), make_operand(f, v), o, f, v, m);
  endtask

  task automatic drain();
    in_valid <= 1'b0;
    step();
    while (exp_q.size() != 0) begin
      step();
    end
  endtask

  task automatic report_test(input string name);
    if (chk_errors + seq_errors == err_mark) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, chk_errors + seq_errors - err_mark);
    end
    err_mark = chk_errors + seq_errors;
  endtask

  // ------------------------------
  // Scoreboard
  // ------------------------------
  always @(posedge clk) begin : scoreboard
    if (rst) begin
      hold_prev = 1'b0;
    end else begin
      if (hold_prev) begin
        assert (out_valid) else begin
          $display("out_valid_o dropped while the output was stalled");
          chk_errors++;
        end
        assert (result == held_result) else begin
          $display("error: result_o stalled got %h expected %h", result, held_result);
          chk_errors++;
        end
        assert (status == held_status) else begin
          $display("error: status_o stalled got %h expected %h", status, held_status);
          chk_errors++;
        end
      end
      if (out_valid && out_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("output transfer with no request outstanding");
          chk_errors++;
        end
        if (exp_q.size() != 0) begin
          pop_exp = exp_q.pop_front();
          assert (result == pop_exp.result) else begin
            $display("error: result_o got %h expected %h", result, pop_exp.result);
            chk_errors++;
          end
          assert (status == pop_exp.status) else begin
            $display("error: status_o got %h expected %h", status, pop_exp.status);
            chk_errors++;
          end
        end
      end
      if (in_valid && in_ready) begin
        push_exp.result = ref_slice(opa, opb, op, fmt, vec, mask, push_st);
        push_exp.status = push_st;
        exp_q.push_back(push_exp);
      end
      hold_prev   = out_valid && !out_ready;
      held_result = result;
      held_status = status;
    end
  end

  initial begin : watchdog
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : main
    fp_word_t    neg0;
    fp_fmt_e     f_sel;
    noncomp_op_e cur_op;
    rst       <= 1'b1;
    opa       <= '0;
    opb       <= '0;
    op        <= OP_SGNJ;
    fmt       <= FMT_FP32;
    vec       <= 1'b0;
    mask      <= '0;
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    bp_on     = 1'b0;
    repeat (2) step();
    rst <= 1'b0;
    step();

    // Idle state, then one op with one cycle latency
    assert (!out_valid) else begin
      $display("error: out_valid_o got %h expected %h", out_valid, 1'b0);
      seq_errors++;
    end
    assert (!busy) else begin
      $display("error: busy_o got %h expected %h", busy, 1'b0);
      seq_errors++;
    end
    assert (in_ready) else begin
      $display("error: in_ready_o got %h expected %h", in_ready, 1'b1);
      seq_errors++;
    end
    send_random(OP_SGNJ, FMT_FP32, 1'b0, 4'b0001);
    in_valid <= 1'b0;
    step();
    assert (out_valid) else begin
      $display("error: out_valid_o got %h expected %h", out_valid, 1'b1);
      seq_errors++;
    end
    assert (busy) else begin
      $display("error: busy_o got %h expected %h", busy, 1'b1);
      seq_errors++;
    end
    drain();
    report_test("reset and latency");

    bp_on = 1'b1;
    for (int k = 0; k < 3; k++) begin
      cur_op = noncomp_op_e'(3'(k));
      for (int unsigned i = 0; i < N_SGNJ; i++) begin
        send_random(cur_op, fp_fmt_e'(2'(i % 3)), 1'b0, 4'b0001);
      end
      drain();
      report_test({"scalar ", cur_op.name()});
    end

    // Signed zeros in both orders, then random min/max
    for (int f = 0; f < 3; f++) begin
      f_sel = fp_fmt_e'(2'(f));
      neg0  = 32'd1 << (ref_width(f_sel) - 1);
      send_op(32'd0, neg0, OP_MIN, f_sel, 1'b0, 4'b0001);
      send_op(neg0, 32'd0, OP_MIN, f_sel, 1'b0, 4'b0001);
      send_op(32'd0, neg0, OP_MAX, f_sel, 1'b0, 4'b0001);
      send_op(neg0, 32'd0, OP_MAX, f_sel, 1'b0, 4'b0001);
    end
    for (int unsigned i = 0; i < N_MINMAX; i++) begin
      cur_op = rand_below(2) != 0 ? OP_MAX : OP_MIN;
      send_random(cur_op, fp_fmt_e'(2'(rand_below(3))), 1'b0, 4'b0001);
    end
    drain();
    report_test("scalar min/max");

    for (int unsigned i = 0; i < N_VEC; i++) begin
      f_sel = rand_below(2) != 0 ? FMT_FP16 : FMT_FP8;
      send_random(noncomp_op_e'(3'(rand_below(5))), f_sel, 1'b1,
                  lane_mask_t'(4'(rand_below(16))));
    end
    drain();
    report_test("vectorial FP16/FP8");

    // Mixed traffic with idle gaps
    for (int unsigned i = 0; i < N_BP; i++) begin
      if (rand_below(4) == 0) begin
        in_valid <= 1'b0;
        step();
      end
      send_random(noncomp_op_e'(3'(rand_below(5))), fp_fmt_e'(2'(rand_below(3))),
                  rand_below(2) != 0, lane_mask_t'(4'(rand_below(16))));
    end
    drain();
    report_test("back-pressure");

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && chk_errors + seq_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hw/fpslice_pkg.sv
hw/lane_operand_select.sv
hw/noncomp_lane.sv
hw/result_pack.sv
hw/simd_fp_slice.sv
testbench/tb_simd_fp_slice.sv
